//--- flist.f
+incdir+include
src/rv_isa_pkg.sv
src/decode_ctrl_pkg.sv
src/decode_stage_if.sv
src/field_split.sv
src/imm_build.sv
src/op_classify.sv
src/rv_decoder_top.sv
sim/tb_rv_decoder.sv

//--- include/rv_decoder_defines.svh
// Width macros for the RV64I decoder, included by the packages, interfaces and stages
`ifndef RV_DECODER_DEFINES_SVH
`define RV_DECODER_DEFINES_SVH

// Datapath width, used for pc and immediate
`define XLEN 64

// Instruction word
`define ILEN 32

// Register index into x0..x31
`define REG_ADDR_W 5

// RV64 shifts use six bits
`define SHAMT_W 6

// Instruction type code, reference numbering
`define INSTR_TYPE_W 8

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_rv_decoder -f flist.f -o tb_rv_decoder
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_rv_decoder 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- sim/tb_rv_decoder.sv
// Testbench for rv_decoder_top that checks random RV64I words against a reference decode model
`timescale 1ns/100ps
`include "rv_decoder_defines.svh"

module tb_rv_decoder;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 400;
    localparam int DRAIN_CYCLES = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES + 20;

    // One expected decode result and the cycle it must appear in
    typedef struct packed {
        logic [31:0]              seq;
        logic [`ILEN-1:0]         word;
        logic [31:0]              done_cycle;
        logic [6:0]               opcode;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`REG_ADDR_W-1:0]   rs1;
        logic [`REG_ADDR_W-1:0]   rs2;
        logic [`XLEN-1:0]         imm;
        logic [`SHAMT_W-1:0]      shamt;
        logic [`INSTR_TYPE_W-1:0] itype;
        logic [2:0]               size;
        logic                     mem_read;
        logic                     mem_write;
        logic [`XLEN-1:0]         pc;
    } expect_t;

    logic                          clk;
    logic                          reset;
    logic                          decode_enable;
    logic [`ILEN-1:0]              instruction;
    logic [`XLEN-1:0]              pc_current;
    rv_isa_pkg::opcode_e           opcode;
    logic [`REG_ADDR_W-1:0]        rd;
    logic [`REG_ADDR_W-1:0]        rs1;
    logic [`REG_ADDR_W-1:0]        rs2;
    logic [`XLEN-1:0]              imm;
    logic [`SHAMT_W-1:0]           shamt;
    decode_ctrl_pkg::instr_type_e  instruction_type;
    decode_ctrl_pkg::access_size_e data_size;
    logic                          mem_read;
    logic                          mem_write;
    logic                          decode_complete;
    logic [`XLEN-1:0]              pc_out;

    integer  seed = 37465;
    int      cycle_count = 0;
    int      issued = 0;
    int      done_count = 0;
    expect_t exp_q[$];

    rv_decoder_top dut_i (
        .clk              (clk),
        .reset            (reset),
        .decode_enable    (decode_enable),
        .instruction      (instruction),
        .pc_current       (pc_current),
        .opcode           (opcode),
        .rd               (rd),
        .rs1              (rs1),
        .rs2              (rs2),
        .imm              (imm),
        .shamt            (shamt),
        .instruction_type (instruction_type),
        .data_size        (data_size),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .decode_complete  (decode_complete),
        .pc_out           (pc_out)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("Error: %s expected 0x%0h actual 0x%0h",
                                     name, expected, actual));
        end
    endtask

    // Keep the low bits and replicate the top one
    function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
        return $signed(v << (64 - bits)) >>> (64 - bits);
    endfunction

    // Reference decode from the RV64I tables
    function automatic expect_t ref_decode(input logic [31:0] w, input logic [63:0] pc);
        expect_t    e;
        logic [2:0] f3;
        logic [6:0] f7;
        e = '0;
        f3 = w[14:12];
        f7 = w[31:25];
        e.word = w;
        e.pc = pc;
        e.opcode = w[6:0];
        e.itype = decode_ctrl_pkg::INVALID;
        e.rd = w[11:7];
        e.rs1 = w[19:15];
        case (w[6:0])
            7'b0110011: begin  // OP
                e.rs2 = w[24:20];
                if (f7 == 7'b0000000) begin
                    case (f3)
                        3'd0: e.itype = decode_ctrl_pkg::ADD;
                        3'd1: e.itype = decode_ctrl_pkg::SLL;
                        3'd2: e.itype = decode_ctrl_pkg::SLT;
                        3'd3: e.itype = decode_ctrl_pkg::SLTU;
                        3'd4: e.itype = decode_ctrl_pkg::XOR;
                        3'd5: e.itype = decode_ctrl_pkg::SRL;
                        3'd6: e.itype = decode_ctrl_pkg::OR;
                        3'd7: e.itype = decode_ctrl_pkg::AND;
                    endcase
                end else if (f7 == 7'b0100000 && f3 == 3'd0) begin
                    e.itype = decode_ctrl_pkg::SUB;
                end else if (f7 == 7'b0100000 && f3 == 3'd5) begin
                    e.itype = decode_ctrl_pkg::SRA;
                end
            end
            7'b0010011: begin  // OP-IMM
                e.imm = sext(64'(w[31:20]), 12);
                case (f3)
                    3'd0: e.itype = decode_ctrl_pkg::ADDI;
                    3'd1: e.itype = decode_ctrl_pkg::SLLI;
                    3'd2: e.itype = decode_ctrl_pkg::SLTI;
                    3'd3: e.itype = decode_ctrl_pkg::SLTIU;
                    3'd4: e.itype = decode_ctrl_pkg::XORI;
                    3'd5: begin
                        if (w[31:26] == 6'b000000) e.itype = decode_ctrl_pkg::SRLI;
                        else if (w[31:26] == 6'b010000) e.itype = decode_ctrl_pkg::SRAI;
                    end
                    3'd6: e.itype = decode_ctrl_pkg::ORI;
                    3'd7: e.itype = decode_ctrl_pkg::ANDI;
                endcase
                if (f3 == 3'd1 || f3 == 3'd5) e.shamt = w[25:20];
            end
            7'b0000011: begin  // LOAD
                e.imm = sext(64'(w[31:20]), 12);
                case (f3)
                    3'd0: {e.itype, e.size} = {decode_ctrl_pkg::LB, 3'd1};
                    3'd1: {e.itype, e.size} = {decode_ctrl_pkg::LH, 3'd2};
                    3'd2: {e.itype, e.size} = {decode_ctrl_pkg::LW, 3'd4};
                    3'd3: {e.itype, e.size} = {decode_ctrl_pkg::LD, 3'd7};
                    3'd4: {e.itype, e.size} = {decode_ctrl_pkg::LBU, 3'd1};
                    3'd5: {e.itype, e.size} = {decode_ctrl_pkg::LHU, 3'd2};
                    3'd6: {e.itype, e.size} = {decode_ctrl_pkg::LWU, 3'd4};
                    default: ;
                endcase
                e.mem_read = (f3 != 3'd7);
            end
            7'b0100011: begin  // STORE
                e.rd = '0;
                e.rs2 = w[24:20];
                e.imm = sext(64'({w[31:25], w[11:7]}), 12);
                if (f3 <= 3'd3) begin
                    e.itype = 8'(decode_ctrl_pkg::SB) + 8'(f3);  // SB..SD are consecutive
                    e.size = (f3 == 3'd0) ? 3'd1 : (f3 == 3'd1) ? 3'd2 :
                             (f3 == 3'd2) ? 3'd4 : 3'd7;
                    e.mem_write = 1'b1;
                end
            end
            7'b1100011: begin  // BRANCH
                e.rd = '0;
                e.rs2 = w[24:20];
                e.imm = sext(64'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
                case (f3)
                    3'd0: e.itype = decode_ctrl_pkg::BEQ;
                    3'd1: e.itype = decode_ctrl_pkg::BNE;
                    3'd4: e.itype = decode_ctrl_pkg::BLT;
                    3'd5: e.itype = decode_ctrl_pkg::BGE;
                    3'd6: e.itype = decode_ctrl_pkg::BLTU;
                    3'd7: e.itype = decode_ctrl_pkg::BGEU;
                    default: ;
                endcase
            end
            7'b1101111: begin  // JAL
                e.rs1 = '0;
                e.imm = sext(64'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
                e.itype = decode_ctrl_pkg::JAL;
            end
            7'b1100111: begin
                e.imm = sext(64'(w[31:20]), 12);
                e.itype = decode_ctrl_pkg::JALR;
            end
            7'b0110111, 7'b0010111: begin  // LUI, AUIPC
                e.rs1 = '0;
                e.imm = sext(64'({w[31:12], 12'b0}), 32);
                e.itype = w[5] ? decode_ctrl_pkg::LUI : decode_ctrl_pkg::AUIPC;
            end
            default: ;  // Unknown opcode keeps raw rd and rs1
        endcase
        return e;
    endfunction

    task automatic gen_word(output logic [31:0] w);
        logic [31:0] pick;
        logic [6:0]  opc_list [0:12];
        opc_list = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011,
                     7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111, 7'b0110011,
                     7'b0010011, 7'b1110011, 7'b0111011};
        w = $random(seed);
        pick = $random(seed);
        w[6:0] = opc_list[4'(pick % 13)];
        pick = $random(seed);
        if (w[6:0] == 7'b0110011 && pick[2:0] != 3'd7) begin
            w[31:25] = pick[2] ? 7'b0100000 : 7'b0000000;  // Rarely left random
        end
        if (w[6:0] == 7'b0010011 && (w[14:12] == 3'd1 || w[14:12] == 3'd5)) begin
            if (pick[4:3] != 2'd3) w[31:26] = pick[5] ? 6'b010000 : 6'b000000;
        end
        if (pick[10:7] == 4'd0) w = '0;
    endtask

    // Stimulus driven shortly after each rising edge
    initial begin
        logic [31:0] w;
        logic [31:0] r;
        logic [63:0] pc;
        logic        en;
        expect_t     e;
        reset = 1'b1;
        decode_enable = 1'b0;
        instruction = '0;
        pc_current = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 reset = 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            #10;
            r = $random(seed);
            en = (r % 5) != 0;
            gen_word(w);
            pc = {$random(seed), $random(seed)};
            decode_enable = en;
            instruction = w;
            pc_current = pc;
            if (en && w != '0) begin
                e = ref_decode(w, pc);
                e.seq = issued;
                e.done_cycle = cycle_count + 3;  // Sampled next edge and out after two more
                exp_q.push_back(e);
                issued++;
            end
        end
        @(posedge clk);
        #10 decode_enable = 1'b0;
        instruction = '0;
        for (int g = 0; g < DRAIN_CYCLES && exp_q.size() != 0; g++) @(negedge clk);
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("Missing results: %0d accepted words never completed", exp_q.size());
            $display("Test FAILED");
            $fatal(1, "Results missing at end of run");
        end else begin
            $display("Checked %0d decoded words out of %0d cycles", done_count, NUM_CYCLES);
            $display("Test OK");
            $finish;
        end
    end

    // Compare at the falling edge where outputs are settled
    always @(negedge clk) begin
        expect_t e;
        string   t;
        if (cycle_count > 0) begin
            if (decode_complete === 1'b1) begin
                if (exp_q.size() == 0) begin
                    report_failure("decode_complete pulsed with no accepted word in flight");
                end else begin
                    e = exp_q.pop_front();
                    t = $sformatf("word %0d (0x%h)", e.seq, e.word);
                    check_value({t, " completion cycle"}, 64'(e.done_cycle),
                                64'(cycle_count));
                    check_value({t, " opcode"}, 64'(e.opcode), 64'(opcode));
                    check_value({t, " instruction_type"}, 64'(e.itype),
                                64'(instruction_type));
                    check_value({t, " rd"}, 64'(e.rd), 64'(rd));
                    check_value({t, " rs1"}, 64'(e.rs1), 64'(rs1));
                    check_value({t, " rs2"}, 64'(e.rs2), 64'(rs2));
                    check_value({t, " imm"}, e.imm, imm);
                    check_value({t, " shamt"}, 64'(e.shamt), 64'(shamt));
                    check_value({t, " data_size"}, 64'(e.size), 64'(data_size));
                    check_value({t, " mem_read"}, 64'(e.mem_read), 64'(mem_read));
                    check_value({t, " mem_write"}, 64'(e.mem_write), 64'(mem_write));
                    check_value({t, " pc_out"}, e.pc, pc_out);
                    done_count++;
                end
            end else begin
                check_value("idle decode_complete", 64'(0), 64'(decode_complete));
                if (done_count == 0) begin  // Nothing decoded yet
                    check_value("idle mem_read", 64'(0), 64'(mem_read));
                    check_value("idle mem_write", 64'(0), 64'(mem_write));
                end
                if (exp_q.size() != 0 && int'(exp_q[0].done_cycle) <= cycle_count) begin
                    report_failure($sformatf("No decode_complete for word %0d when it was due",
                                             exp_q[0].seq));
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock periods", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1, "Timeout");
    end

endmodule

//--- src/decode_ctrl_pkg.sv
// Decoder result types (instruction type codes and memory access sizes) seen at the outputs
`include "rv_decoder_defines.svh"

package decode_ctrl_pkg;

    // Numbering follows the existing core so downstream tables stay valid
    typedef enum logic [`INSTR_TYPE_W-1:0] {
        ADD     = 8'd0,
        SUB     = 8'd1,
        XOR     = 8'd2,
        OR      = 8'd3,
        AND     = 8'd4,
        SLL     = 8'd5,
        SRL     = 8'd6,
        SRA     = 8'd7,
        SLT     = 8'd8,
        SLTU    = 8'd9,
        ADDI    = 8'd18,
        XORI    = 8'd19,
        ORI     = 8'd20,
        ANDI    = 8'd21,
        SLLI    = 8'd22,
        SRLI    = 8'd23,
        SRAI    = 8'd24,
        SLTI    = 8'd25,
        SLTIU   = 8'd26,
        SB      = 8'd43,
        SH      = 8'd44,
        SW      = 8'd45,
        SD      = 8'd46,
        BEQ     = 8'd47,
        BNE     = 8'd48,
        BLT     = 8'd49,
        BGE     = 8'd50,
        BLTU    = 8'd51,
        BGEU    = 8'd52,
        JAL     = 8'd53,
        JALR    = 8'd54,
        LUI     = 8'd55,
        AUIPC   = 8'd56,
        LB      = 8'd59,
        LH      = 8'd60,
        LW      = 8'd61,
        LBU     = 8'd62,
        LHU     = 8'd63,
        LWU     = 8'd64,
        LD      = 8'd65,
        INVALID = 8'd255
    } instr_type_e;

    // Access size codes as the memory stage expects them
    typedef enum logic [2:0] {
        SIZE_NONE   = 3'd0,
        SIZE_BYTE   = 3'd1,
        SIZE_HALF   = 3'd2,
        SIZE_WORD   = 3'd4,
        SIZE_DOUBLE = 3'd7  // Not a byte count, kept for compatibility
    } access_size_e;

endpackage

//--- src/decode_stage_if.sv
// Stage-to-stage buses of the decoder pipeline, driven through source and read through sink
`timescale 1ns/100ps
`include "rv_decoder_defines.svh"

// Stage 1 to stage 2
interface split_if;
    logic                valid;   // Qualifies the rest for one cycle
    logic [`XLEN-1:0]    pc;
    logic [`ILEN-1:0]    instr;
    rv_isa_pkg::format_e format;

    modport source (output valid, pc, instr, format);
    modport sink   (input valid, pc, instr, format);
endinterface

// Stage 2 to stage 3, adds the built immediate and shift amount
interface imm_if;
    logic                valid;
    logic [`XLEN-1:0]    pc;
    logic [`ILEN-1:0]    instr;
    rv_isa_pkg::format_e format;
    logic [`XLEN-1:0]    imm;     // Already sign-extended
    logic [`SHAMT_W-1:0] shamt;

    modport source (output valid, pc, instr, format, imm, shamt);
    modport sink   (input valid, pc, instr, format, imm, shamt);
endinterface

//--- src/field_split.sv
// Decoder stage 1, samples an enabled nonzero instruction and tags it with its encoding format
`timescale 1ns/100ps
`include "rv_decoder_defines.svh"

module field_split (
    input  logic             clk,
    input  logic             reset,
    input  logic             decode_enable,
    input  logic [`ILEN-1:0] instruction,
    input  logic [`XLEN-1:0] pc,
    split_if.source          out
);

    logic                accept;
    rv_isa_pkg::format_e format_next;

    // All-zero word means nothing to decode
    assign accept = decode_enable && (instruction != '0);

    always_comb begin
        case (rv_isa_pkg::opcode_e'(instruction[6:0]))
            rv_isa_pkg::OP:     format_next = rv_isa_pkg::FMT_R;
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::LOAD,
            rv_isa_pkg::JALR:   format_next = rv_isa_pkg::FMT_I;
            rv_isa_pkg::STORE:  format_next = rv_isa_pkg::FMT_S;
            rv_isa_pkg::BRANCH: format_next = rv_isa_pkg::FMT_B;
            rv_isa_pkg::LUI,
            rv_isa_pkg::AUIPC:  format_next = rv_isa_pkg::FMT_U;
            rv_isa_pkg::JAL:    format_next = rv_isa_pkg::FMT_J;
            default:            format_next = rv_isa_pkg::FMT_BAD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= accept;
        end
    end

    // Payload only moves on an accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            out.pc     <= pc;
            out.instr  <= instruction;
            out.format <= format_next;
        end
    end

endmodule

//--- src/imm_build.sv
// Decoder stage 2, builds the sign-extended immediate for the word's format and the shift amount
`timescale 1ns/100ps
`include "rv_decoder_defines.svh"

module imm_build (
    input  logic    clk,
    input  logic    reset,
    split_if.sink   in,
    imm_if.source   out
);

    logic [`ILEN-1:0]    w;
    logic [`XLEN-1:0]    imm_next;
    logic [`SHAMT_W-1:0] shamt_next;
    logic                is_shift_imm;

    assign w = in.instr;

    always_comb begin
        case (in.format)
            rv_isa_pkg::FMT_I: imm_next = {{(`XLEN-12){w[31]}}, w[31:20]};
            rv_isa_pkg::FMT_S: imm_next = {{(`XLEN-12){w[31]}}, w[31:25], w[11:7]};
            rv_isa_pkg::FMT_B: imm_next = {{(`XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_isa_pkg::FMT_U: imm_next = {{(`XLEN-32){w[31]}}, w[31:12], 12'b0};
            rv_isa_pkg::FMT_J: imm_next = {{(`XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:           imm_next = '0;  // R and unknown carry no immediate
        endcase
    end

    // SLLI, SRLI, SRAI
    assign is_shift_imm = (w[6:0] == rv_isa_pkg::OP_IMM) &&
                          ((w[14:12] == rv_isa_pkg::F3_SLL) || (w[14:12] == rv_isa_pkg::F3_SR));
    assign shamt_next   = is_shift_imm ? w[20 +: `SHAMT_W] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.pc     <= in.pc;
            out.instr  <= in.instr;
            out.format <= in.format;
            out.imm    <= imm_next;
            out.shamt  <= shamt_next;
        end
    end

endmodule

//--- src/op_classify.sv
// Decoder stage 3, selects the instruction type and memory controls and registers all results
`timescale 1ns/100ps
`include "rv_decoder_defines.svh"

module op_classify (
    input  logic                          clk,
    input  logic                          reset,
    imm_if.sink                           in,
    output rv_isa_pkg::opcode_e           opcode,
    output logic [`REG_ADDR_W-1:0]        rd,
    output logic [`REG_ADDR_W-1:0]        rs1,
    output logic [`REG_ADDR_W-1:0]        rs2,
    output logic [`XLEN-1:0]              imm,
    output logic [`SHAMT_W-1:0]           shamt,
    output decode_ctrl_pkg::instr_type_e  instruction_type,
    output decode_ctrl_pkg::access_size_e data_size,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          decode_complete,
    output logic [`XLEN-1:0]              pc_out
);

    rv_isa_pkg::opcode_e           opc;
    rv_isa_pkg::alu_f3_e           alu_f3;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    decode_ctrl_pkg::instr_type_e  type_next;
    decode_ctrl_pkg::access_size_e size_next;
    logic [`REG_ADDR_W-1:0]        rd_next;
    logic [`REG_ADDR_W-1:0]        rs1_next;
    logic [`REG_ADDR_W-1:0]        rs2_next;
    logic                          known;

    assign opc    = rv_isa_pkg::opcode_e'(in.instr[6:0]);
    assign funct3 = in.instr[14:12];
    assign alu_f3 = rv_isa_pkg::alu_f3_e'(funct3);
    assign funct7 = in.instr[31:25];
    assign known  = (type_next != decode_ctrl_pkg::INVALID);

    always_comb begin
        type_next = decode_ctrl_pkg::INVALID;  // Anything not matched below
        case (opc)
            rv_isa_pkg::OP: begin
                if (funct7 == rv_isa_pkg::FUNCT7_BASE) begin
                    case (alu_f3)
                        rv_isa_pkg::F3_ADD:  type_next = decode_ctrl_pkg::ADD;
                        rv_isa_pkg::F3_SLL:  type_next = decode_ctrl_pkg::SLL;
                        rv_isa_pkg::F3_SLT:  type_next = decode_ctrl_pkg::SLT;
                        rv_isa_pkg::F3_SLTU: type_next = decode_ctrl_pkg::SLTU;
                        rv_isa_pkg::F3_XOR:  type_next = decode_ctrl_pkg::XOR;
                        rv_isa_pkg::F3_SR:   type_next = decode_ctrl_pkg::SRL;
                        rv_isa_pkg::F3_OR:   type_next = decode_ctrl_pkg::OR;
                        rv_isa_pkg::F3_AND:  type_next = decode_ctrl_pkg::AND;
                    endcase
                end else if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
                    if (alu_f3 == rv_isa_pkg::F3_ADD) begin
                        type_next = decode_ctrl_pkg::SUB;
                    end else if (alu_f3 == rv_isa_pkg::F3_SR) begin
                        type_next = decode_ctrl_pkg::SRA;
                    end
                end
            end
            rv_isa_pkg::OP_IMM: begin
                case (alu_f3)
                    rv_isa_pkg::F3_ADD:  type_next = decode_ctrl_pkg::ADDI;
                    rv_isa_pkg::F3_SLL:  type_next = decode_ctrl_pkg::SLLI;
                    rv_isa_pkg::F3_SLT:  type_next = decode_ctrl_pkg::SLTI;
                    rv_isa_pkg::F3_SLTU: type_next = decode_ctrl_pkg::SLTIU;
                    rv_isa_pkg::F3_XOR:  type_next = decode_ctrl_pkg::XORI;
                    rv_isa_pkg::F3_OR:   type_next = decode_ctrl_pkg::ORI;
                    rv_isa_pkg::F3_AND:  type_next = decode_ctrl_pkg::ANDI;
                    rv_isa_pkg::F3_SR: begin
                        if (in.instr[31:26] == rv_isa_pkg::SHIFT_HI_BASE) begin
                            type_next = decode_ctrl_pkg::SRLI;
                        end else if (in.instr[31:26] == rv_isa_pkg::SHIFT_HI_ALT) begin
                            type_next = decode_ctrl_pkg::SRAI;
                        end
                    end
                endcase
            end
            rv_isa_pkg::LOAD: begin
                case (funct3)
                    3'b000:  type_next = decode_ctrl_pkg::LB;
                    3'b001:  type_next = decode_ctrl_pkg::LH;
                    3'b010:  type_next = decode_ctrl_pkg::LW;
                    3'b011:  type_next = decode_ctrl_pkg::LD;
                    3'b100:  type_next = decode_ctrl_pkg::LBU;
                    3'b101:  type_next = decode_ctrl_pkg::LHU;
                    3'b110:  type_next = decode_ctrl_pkg::LWU;
                    default: type_next = decode_ctrl_pkg::INVALID;
                endcase
            end
            rv_isa_pkg::STORE: begin
                case (funct3)
                    3'b000:  type_next = decode_ctrl_pkg::SB;
                    3'b001:  type_next = decode_ctrl_pkg::SH;
                    3'b010:  type_next = decode_ctrl_pkg::SW;
                    3'b011:  type_next = decode_ctrl_pkg::SD;
                    default: type_next = decode_ctrl_pkg::INVALID;
                endcase
            end
            rv_isa_pkg::BRANCH: begin
                case (funct3)
                    3'b000:  type_next = decode_ctrl_pkg::BEQ;
                    3'b001:  type_next = decode_ctrl_pkg::BNE;
                    3'b100:  type_next = decode_ctrl_pkg::BLT;
                    3'b101:  type_next = decode_ctrl_pkg::BGE;
                    3'b110:  type_next = decode_ctrl_pkg::BLTU;
                    3'b111:  type_next = decode_ctrl_pkg::BGEU;
                    default: type_next = decode_ctrl_pkg::INVALID;
                endcase
            end
            rv_isa_pkg::JAL:   type_next = decode_ctrl_pkg::JAL;
            rv_isa_pkg::JALR:  type_next = decode_ctrl_pkg::JALR;  // funct3 not checked
            rv_isa_pkg::LUI:   type_next = decode_ctrl_pkg::LUI;
            rv_isa_pkg::AUIPC: type_next = decode_ctrl_pkg::AUIPC;
            default:           type_next = decode_ctrl_pkg::INVALID;
        endcase
    end

    // Size follows the type, so invalid loads and stores get none
    always_comb begin
        case (type_next)
            decode_ctrl_pkg::LB, decode_ctrl_pkg::LBU, decode_ctrl_pkg::SB:
                size_next = decode_ctrl_pkg::SIZE_BYTE;
            decode_ctrl_pkg::LH, decode_ctrl_pkg::LHU, decode_ctrl_pkg::SH:
                size_next = decode_ctrl_pkg::SIZE_HALF;
            decode_ctrl_pkg::LW, decode_ctrl_pkg::LWU, decode_ctrl_pkg::SW:
                size_next = decode_ctrl_pkg::SIZE_WORD;
            decode_ctrl_pkg::LD, decode_ctrl_pkg::SD:
                size_next = decode_ctrl_pkg::SIZE_DOUBLE;
            default:
                size_next = decode_ctrl_pkg::SIZE_NONE;
        endcase
    end

    // Register fields a format does not use read as zero
    always_comb begin
        rd_next  = in.instr[11:7];
        rs1_next = in.instr[19:15];
        rs2_next = '0;
        case (in.format)
            rv_isa_pkg::FMT_R: rs2_next = in.instr[24:20];
            rv_isa_pkg::FMT_S,
            rv_isa_pkg::FMT_B: begin
                rd_next  = '0;
                rs2_next = in.instr[24:20];
            end
            rv_isa_pkg::FMT_U,
            rv_isa_pkg::FMT_J: rs1_next = '0;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_complete  <= 1'b0;
            opcode           <= rv_isa_pkg::opcode_e'('0);
            rd               <= '0;
            rs1              <= '0;
            rs2              <= '0;
            imm              <= '0;
            shamt            <= '0;
            instruction_type <= decode_ctrl_pkg::instr_type_e'('0);
            data_size        <= decode_ctrl_pkg::SIZE_NONE;
            mem_read         <= 1'b0;
            mem_write        <= 1'b0;
            pc_out           <= '0;
        end else begin
            decode_complete <= in.valid;  // One pulse per decoded word
            if (in.valid) begin
                opcode           <= opc;
                rd               <= rd_next;
                rs1              <= rs1_next;
                rs2              <= rs2_next;
                imm              <= in.imm;
                shamt            <= in.shamt;
                instruction_type <= type_next;
                data_size        <= size_next;
                mem_read         <= (opc == rv_isa_pkg::LOAD) && known;
                mem_write        <= (opc == rv_isa_pkg::STORE) && known;
                pc_out           <= in.pc;
            end
        end
    end

endmodule

//--- src/rv_decoder_top.sv
// Top of the three-stage RV64I decoder, fixed three-edge latency and one word per cycle
`timescale 1ns/100ps
`include "rv_decoder_defines.svh"

module rv_decoder_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          decode_enable,
    input  logic [`ILEN-1:0]              instruction,
    input  logic [`XLEN-1:0]              pc_current,
    output rv_isa_pkg::opcode_e           opcode,
    output logic [`REG_ADDR_W-1:0]        rd,
    output logic [`REG_ADDR_W-1:0]        rs1,
    output logic [`REG_ADDR_W-1:0]        rs2,
    output logic [`XLEN-1:0]              imm,
    output logic [`SHAMT_W-1:0]           shamt,
    output decode_ctrl_pkg::instr_type_e  instruction_type,
    output decode_ctrl_pkg::access_size_e data_size,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          decode_complete,
    output logic [`XLEN-1:0]              pc_out
);

    split_if split_bus ();
    imm_if   imm_bus ();

    field_split split_i (
        .clk           (clk),
        .reset         (reset),
        .decode_enable (decode_enable),
        .instruction   (instruction),
        .pc            (pc_current),
        .out           (split_bus.source)
    );

    imm_build imm_i (
        .clk   (clk),
        .reset (reset),
        .in    (split_bus.sink),
        .out   (imm_bus.source)
    );

    op_classify class_i (
        .clk              (clk),
        .reset            (reset),
        .in               (imm_bus.sink),
        .opcode           (opcode),
        .rd               (rd),
        .rs1              (rs1),
        .rs2              (rs2),
        .imm              (imm),
        .shamt            (shamt),
        .instruction_type (instruction_type),
        .data_size        (data_size),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .decode_complete  (decode_complete),
        .pc_out           (pc_out)
    );

endmodule

//--- src/rv_isa_pkg.sv
// RV64I encoding types (major opcodes, formats, funct fields) shared by the decoder stages
package rv_isa_pkg;

    // Major opcodes, bits 6:0 of the word
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // Encoding format, picks the immediate layout and used register fields
    typedef enum logic [2:0] {
        FMT_R   = 3'd0,
        FMT_I   = 3'd1,
        FMT_S   = 3'd2,
        FMT_B   = 3'd3,
        FMT_U   = 3'd4,
        FMT_J   = 3'd5,
        FMT_BAD = 3'd6   // Opcode not in the kept set
    } format_e;

    // ALU funct3, common to OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // SRL or SRA by funct7
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    // funct7 for OP
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // SUB, SRA

    // Bits 31:26 of an immediate shift, bit 25 belongs to shamt
    localparam logic [5:0] SHIFT_HI_BASE = 6'b000000;
    localparam logic [5:0] SHIFT_HI_ALT  = 6'b010000;

endpackage
